/* src/sha256_pkg.sv */
`default_nettype none

package sha256_pkg;

	typedef logic [31:0]  sha_word_t;    // One message or state word
	typedef logic [511:0] sha_block_t;   // 16 words, first word in top bits
	typedef logic [255:0] sha_digest_t;  // 8 words, a in top bits
	typedef logic [2:0]   sha_nbytes_t;  // Valid bytes in a word, 1 to 4

	////////////////////////////////////////////////////////////////////////////
	// FIPS 180-4 round constants

	localparam sha_word_t SHA_K [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Initial hash value, H0[0] first
	localparam sha_digest_t SHA_H0 = {
		32'h6a09e667, 32'hbb67ae85,
		32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c,
		32'h1f83d9ab, 32'h5be0cd19
	};

endpackage

`default_nettype wire

/* src/hmac_pkg.sv */
`default_nettype none

package hmac_pkg;

	// Key up to 64 bytes, zero padded on the right, first byte in top bits
	typedef logic [511:0] hmac_key_t;

	localparam logic [7:0] IPAD_BYTE = 8'h36;  // Inner pad
	localparam logic [7:0] OPAD_BYTE = 8'h5c;  // Outer pad

	// Sequencer for the two hash passes
	typedef enum logic [2:0] {
		ST_IDLE     = 3'd0,  // Waiting for start
		ST_IN_PAD   = 3'd1,  // Feeding ipad block
		ST_MESSAGE  = 3'd2,  // User words pass through
		ST_IN_WAIT  = 3'd3,  // Inner digest pending
		ST_OUT_PAD  = 3'd4,  // Feeding opad block
		ST_REHASH   = 3'd5,  // Feeding inner digest
		ST_FINALIZE = 3'd6,  // Close outer pass
		ST_OUT_WAIT = 3'd7   // Outer digest pending
	} hmac_state_t;

endpackage

`default_nettype wire

/* src/sha256_padder.sv */
`timescale 1ns/10ps
`default_nettype none

module sha256_padder (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic                    update,
	input  sha256_pkg::sha_word_t   data_in,
	input  sha256_pkg::sha_nbytes_t nbytes,
	input  logic                    finalize,
	input  logic                    done,
	output logic                    word_ready,
	output logic                    block_strobe,
	output sha256_pkg::sha_block_t  block,
	output logic                    last_block
);

	import sha256_pkg::*;

	logic [3:0]  wcnt;        // Words held in the current block
	logic [63:0] byte_cnt;    // Message bytes so far
	logic        marker_set;  // 0x80 already placed by a partial word
	logic        busy;        // Block out at the compressor
	logic        len_pend;    // Length-only block still owed

	logic        accept;
	logic        fin_go;
	logic        len_go;
	logic [8:0]  slot;        // Bit offset of word wcnt
	logic [4:0]  used;        // Words occupied once the marker is in
	logic        two_blk;
	logic [63:0] bit_len;
	sha_word_t   in_word;
	sha_block_t  padded;

	assign word_ready = !busy;
	assign accept     = update && word_ready;
	assign fin_go     = finalize && word_ready;
	assign len_go     = done && len_pend;

	assign slot    = {4'd15 - wcnt, 5'd0};
	assign used    = {1'b0, wcnt} + {4'd0, !marker_set};
	assign two_blk = used > 5'd14;  // No room left for the length words
	assign bit_len = {byte_cnt[60:0], 3'b000};

	// Partial word gets its 0x80 right away, valid bytes are left aligned
	always_comb begin
		case (nbytes)
			3'd1:    in_word = {data_in[31:24], 8'h80, 16'h0000};
			3'd2:    in_word = {data_in[31:16], 8'h80, 8'h00};
			3'd3:    in_word = {data_in[31:8], 8'h80};
			default: in_word = data_in;
		endcase
	end

	// Closing block built in one step at finalize
	always_comb begin
		padded = block;
		if (!marker_set)
			padded[slot +: 32] = 32'h8000_0000;
		if (!two_blk)
			padded[63:0] = bit_len;  // Length fits in words 14 and 15
	end

	////////////////////////////////////////////////////////////////////////////
	// Block buffer

	always_ff @(posedge clk) begin
		if (start)
			block <= '0;
		else if (accept)
			block[slot +: 32] <= in_word;
		else if (fin_go)
			block <= padded;
		else if (block_strobe)
			block <= '0;             // Compressor took its copy on this edge
		else if (len_go)
			block[63:0] <= bit_len;  // Zero fill already in place
	end

	////////////////////////////////////////////////////////////////////////////
	// Counters and block issue

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wcnt         <= '0;
			byte_cnt     <= '0;
			marker_set   <= 1'b0;
			busy         <= 1'b0;
			len_pend     <= 1'b0;
			block_strobe <= 1'b0;
			last_block   <= 1'b0;
		end else begin
			block_strobe <= 1'b0;
			if (start) begin
				wcnt       <= '0;
				byte_cnt   <= '0;
				marker_set <= 1'b0;
				busy       <= 1'b0;
				len_pend   <= 1'b0;
			end else if (accept) begin
				wcnt     <= wcnt + 4'd1;  // Wraps to 0 on the 16th word
				byte_cnt <= byte_cnt + {61'd0, nbytes};
				if (nbytes != 3'd4)
					marker_set <= 1'b1;
				if (wcnt == 4'd15) begin
					block_strobe <= 1'b1;
					busy         <= 1'b1;
					last_block   <= 1'b0;
				end
			end else if (fin_go) begin
				wcnt         <= '0;
				block_strobe <= 1'b1;
				busy         <= 1'b1;
				last_block   <= !two_blk;
				len_pend     <= two_blk;
			end else if (done) begin
				if (len_pend) begin
					block_strobe <= 1'b1;  // Stay busy for the length block
					last_block   <= 1'b1;
					len_pend     <= 1'b0;
				end else begin
					busy <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/sha256_compress.sv */
`timescale 1ns/10ps
`default_nettype none

module sha256_compress (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    block_strobe,
	input  sha256_pkg::sha_block_t  block,
	input  sha256_pkg::sha_digest_t chain_in,
	output logic                    done,
	output sha256_pkg::sha_digest_t chain_out
);

	import sha256_pkg::*;

	function automatic sha_word_t rotr(input sha_word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic sha_word_t bsig0(input sha_word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic sha_word_t bsig1(input sha_word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic sha_word_t ssig0(input sha_word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic sha_word_t ssig1(input sha_word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	sha_word_t   a, b, c, d, e, f, g, h;  // Working variables
	sha_word_t   w [0:15];                // w[i] holds W[t+i]
	sha_word_t   t1, t2;
	sha_word_t   a_n, e_n;
	sha_word_t   w_new;                   // W[t+16]
	sha_digest_t nxt;                     // Variables after this round
	logic [5:0]  rnd;
	logic        busy;
	logic        last_rnd;

	assign last_rnd = busy && (rnd == 6'd63);

	////////////////////////////////////////////////////////////////////////////
	// One round

	always_comb begin
		t1    = h + bsig1(e) + ((e & f) ^ (~e & g)) + SHA_K[rnd] + w[0];
		t2    = bsig0(a) + ((a & b) ^ (a & c) ^ (b & c));
		a_n   = t1 + t2;
		e_n   = d + t1;
		nxt   = {a_n, a, b, c, e_n, e, f, g};  // Others just shift down
		w_new = ssig1(w[14]) + w[9] + ssig0(w[1]) + w[0];
	end

	always_ff @(posedge clk) begin
		if (block_strobe) begin
			{a, b, c, d, e, f, g, h} <= chain_in;
			for (int i = 0; i < 16; i++)
				w[i] <= block[(15 - i) * 32 +: 32];
		end else if (busy) begin
			{a, b, c, d, e, f, g, h} <= nxt;
			for (int i = 0; i < 15; i++)
				w[i] <= w[i + 1];  // Slide the schedule window
			w[15] <= w_new;
			// Feed-forward folded into round 63
			if (last_rnd) begin
				for (int i = 0; i < 8; i++)
					chain_out[i * 32 +: 32] <= chain_in[i * 32 +: 32] + nxt[i * 32 +: 32];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Round counter

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			rnd  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (block_strobe) begin
				busy <= 1'b1;
				rnd  <= '0;
			end else if (busy) begin
				rnd <= rnd + 6'd1;
				if (last_rnd) begin
					busy <= 1'b0;
					done <= 1'b1;  // 65 cycles after the strobe
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/streaming_sha256.sv */
`timescale 1ns/10ps
`default_nettype none

module streaming_sha256 (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic                    update,
	input  sha256_pkg::sha_word_t   data_in,
	input  sha256_pkg::sha_nbytes_t nbytes,
	input  logic                    finalize,
	output logic                    word_ready,
	output logic                    digest_valid,
	output sha256_pkg::sha_digest_t digest
);

	import sha256_pkg::*;

	sha_block_t  blk;
	logic        block_strobe;
	logic        last_block;
	logic        done;
	sha_digest_t chain;      // Chaining state
	sha_digest_t chain_out;

	sha256_padder u_padder (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.update       (update),
		.data_in      (data_in),
		.nbytes       (nbytes),
		.finalize     (finalize),
		.done         (done),
		.word_ready   (word_ready),
		.block_strobe (block_strobe),
		.block        (blk),
		.last_block   (last_block)
	);

	sha256_compress u_compress (
		.clk          (clk),
		.rst_n        (rst_n),
		.block_strobe (block_strobe),
		.block        (blk),
		.chain_in     (chain),
		.done         (done),
		.chain_out    (chain_out)
	);

	// Digest held until the next last block, so it survives a new start
	always_ff @(posedge clk) begin
		if (start)
			chain <= SHA_H0;
		else if (done)
			chain <= chain_out;
		if (done && last_block)
			digest <= chain_out;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			digest_valid <= 1'b0;
		else
			digest_valid <= done && last_block;
	end

endmodule

`default_nettype wire

/* src/hmac_sha256_core.sv */
`timescale 1ns/10ps
`default_nettype none

module hmac_sha256_core (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    key_update,
	input  hmac_pkg::hmac_key_t     key,
	input  logic                    start,
	input  logic                    update,
	input  sha256_pkg::sha_word_t   data_in,
	input  sha256_pkg::sha_nbytes_t bytes_valid,
	input  logic                    finalize,
	output logic                    ready,
	output logic                    hash_valid,
	output sha256_pkg::sha_digest_t hash
);

	import sha256_pkg::*;
	import hmac_pkg::*;

	hmac_key_t   ipad;
	hmac_key_t   opad;
	hmac_state_t state;
	logic [3:0]  cnt;         // Pad word or digest word index
	logic        fin_pend;    // User finalize waiting on word_ready

	logic        sha_start;
	logic        sha_update;
	sha_word_t   sha_data;
	sha_nbytes_t sha_nbytes;
	logic        sha_finalize;
	logic        word_ready;
	logic        digest_valid;
	sha_digest_t sha_digest;  // Inner digest during the outer pass

	////////////////////////////////////////////////////////////////////////////
	// Key pads

	always_ff @(posedge clk) begin
		if (key_update) begin
			for (int i = 0; i < 64; i++) begin
				ipad[i * 8 +: 8] <= key[i * 8 +: 8] ^ IPAD_BYTE;
				opad[i * 8 +: 8] <= key[i * 8 +: 8] ^ OPAD_BYTE;
			end
		end
	end

	streaming_sha256 u_sha (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (sha_start),
		.update       (sha_update),
		.data_in      (sha_data),
		.nbytes       (sha_nbytes),
		.finalize     (sha_finalize),
		.word_ready   (word_ready),
		.digest_valid (digest_valid),
		.digest       (sha_digest)
	);

	// User sees ready only between the ipad block and finalize
	assign ready = (state == ST_MESSAGE) && word_ready && !fin_pend;

	////////////////////////////////////////////////////////////////////////////
	// Hasher drive

	always_comb begin
		sha_start    = 1'b0;
		sha_update   = 1'b0;
		sha_finalize = 1'b0;
		sha_data     = ipad[(4'd15 - cnt) * 32 +: 32];
		sha_nbytes   = 3'd4;  // Full words except user traffic
		case (state)
			ST_IDLE:     sha_start = start;
			ST_IN_PAD:   sha_update = word_ready;
			ST_MESSAGE: begin
				sha_update   = update && ready;  // Word under back-pressure dropped
				sha_data     = data_in;
				sha_nbytes   = bytes_valid;
				sha_finalize = (finalize || fin_pend) && word_ready;
			end
			ST_IN_WAIT:  sha_start = digest_valid;  // Outer pass starts at once
			ST_OUT_PAD: begin
				sha_update = word_ready;
				sha_data   = opad[(4'd15 - cnt) * 32 +: 32];
			end
			ST_REHASH: begin
				sha_update = word_ready;
				sha_data   = sha_digest[(3'd7 - cnt[2:0]) * 32 +: 32];
			end
			ST_FINALIZE: sha_finalize = word_ready;
			default:     sha_start = 1'b0;  // Outer digest pending
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			cnt        <= '0;
			fin_pend   <= 1'b0;
			hash_valid <= 1'b0;
		end else begin
			hash_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					cnt <= '0;
					if (start)
						state <= ST_IN_PAD;
				end
				ST_IN_PAD: begin
					if (word_ready) begin
						cnt <= cnt + 4'd1;  // Wraps to 0 after word 15
						if (cnt == 4'd15)
							state <= ST_MESSAGE;
					end
				end
				ST_MESSAGE: begin
					if (sha_finalize) begin
						fin_pend <= 1'b0;
						state    <= ST_IN_WAIT;
					end else if (finalize) begin
						fin_pend <= 1'b1;  // Block still compressing
					end
				end
				ST_IN_WAIT: begin
					cnt <= '0;
					if (digest_valid)
						state <= ST_OUT_PAD;
				end
				ST_OUT_PAD: begin
					if (word_ready) begin
						cnt <= cnt + 4'd1;
						if (cnt == 4'd15)
							state <= ST_REHASH;
					end
				end
				ST_REHASH: begin
					if (word_ready) begin
						cnt <= cnt + 4'd1;
						if (cnt == 4'd7) begin
							cnt   <= '0;
							state <= ST_FINALIZE;
						end
					end
				end
				ST_FINALIZE: begin
					if (word_ready)
						state <= ST_OUT_WAIT;
				end
				ST_OUT_WAIT: begin
					if (digest_valid) begin
						hash_valid <= 1'b1;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// MAC held until the next outer digest
	always_ff @(posedge clk) begin
		if (state == ST_OUT_WAIT && digest_valid)
			hash <= sha_digest;
	end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam time HALF_PERIOD  = 10ns;  // 20 ns clock
	localparam int  RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Release just after an edge, same phase as the stimulus
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* verification/hmac_sha256_core_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module hmac_sha256_core_sva (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  update,
	input logic                  finalize,
	input logic                  ready,
	input logic                  hash_valid,
	input hmac_pkg::hmac_state_t state
);

	import hmac_pkg::*;

	int fail_cnt = 0;  // Failed assertions so far

	////////////////////////////////////////////////////////////////////////////
	// Core protocol

	// MAC strobe is one cycle wide
	a_hash_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		hash_valid |=> !hash_valid)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("hash_valid stayed high for more than one cycle");
		end

	// Back-pressure must be honored
	a_update_ready: assert property (@(posedge clk) disable iff (!rst_n)
		update |-> ready)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("update given while ready was low");
		end

	a_finalize_state: assert property (@(posedge clk) disable iff (!rst_n)
		finalize |-> (state == ST_MESSAGE))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("finalize given outside the message phase");
		end

	// ready ends with the message phase
	a_ready_state: assert property (@(posedge clk) disable iff (!rst_n)
		finalize |=> !ready)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("ready still high after finalize closed the message phase");
		end

endmodule

`default_nettype wire

/* verification/hmac_sha256_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module hmac_sha256_tb;

	import sha256_pkg::*;
	import hmac_pkg::*;

	typedef logic [7:0] byte_q_t [$];

	logic        clk;
	logic        rst_n;
	logic        key_update;
	hmac_key_t   key;
	logic        start;
	logic        update;
	sha_word_t   data_in;
	sha_nbytes_t bytes_valid;
	logic        finalize;
	logic        ready;
	logic        hash_valid;
	sha_digest_t hash;

	// Test table with one index per test
	string        test_name [$];
	hmac_key_t    test_key [$];
	logic [511:0] test_msg [$];  // First message byte in top bits
	int           test_len [$];  // Bytes
	sha_digest_t  test_mac [$];  // RFC 4231 value or zero if none published

	hmac_key_t cur_key;
	logic      key_loaded  = 1'b0;
	int        cycle_cnt   = 0;
	int        cycle_limit = 0;  // Zero until the table is known

	tb_clock_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	hmac_sha256_core DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.key_update  (key_update),
		.key         (key),
		.start       (start),
		.update      (update),
		.data_in     (data_in),
		.bytes_valid (bytes_valid),
		.finalize    (finalize),
		.ready       (ready),
		.hash_valid  (hash_valid),
		.hash        (hash)
	);

	bind hmac_sha256_core hmac_sha256_core_sva u_sva (
		.clk        (clk),
		.rst_n      (rst_n),
		.update     (update),
		.finalize   (finalize),
		.ready      (ready),
		.hash_valid (hash_valid),
		.state      (state)
	);

	task automatic stop_with_failure();
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_digest(input string name, input sha_digest_t expected,
		input sha_digest_t actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	// Watchdog and bound protocol checker
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (DUT.u_sva.fail_cnt != 0) begin
			$display("A protocol assertion on the core failed");
			stop_with_failure();
		end else if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: no MAC after %0d cycles", cycle_cnt);
			stop_with_failure();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference HMAC-SHA-256 after FIPS 180-4 and RFC 2104

	function automatic sha_word_t ror(input sha_word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic sha_digest_t compress_ref(input sha_digest_t st,
		input sha_block_t blk);
		sha_word_t   w [0:63];   // Full schedule
		sha_word_t   v [0:7];    // a to h
		sha_word_t   s0, s1, t1, t2;
		sha_digest_t res;
		for (int t = 0; t < 16; t++)
			w[t] = blk[511 - 32 * t -: 32];
		for (int t = 16; t < 64; t++) begin
			s0   = ror(w[t - 15], 7) ^ ror(w[t - 15], 18) ^ (w[t - 15] >> 3);
			s1   = ror(w[t - 2], 17) ^ ror(w[t - 2], 19) ^ (w[t - 2] >> 10);
			w[t] = w[t - 16] + s0 + w[t - 7] + s1;
		end
		for (int i = 0; i < 8; i++)
			v[i] = st[255 - 32 * i -: 32];
		for (int t = 0; t < 64; t++) begin
			s1 = ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25);
			t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + SHA_K[t] + w[t];
			s0 = ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22);
			t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int i = 7; i > 0; i--)
				v[i] = v[i - 1];
			v[4] = v[4] + t1;  // Old d plus t1
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++)
			res[255 - 32 * i -: 32] = st[255 - 32 * i -: 32] + v[i];
		return res;
	endfunction

	function automatic sha_digest_t sha256_ref(input byte_q_t msg);
		byte_q_t     pad_q;
		logic [63:0] nbits;
		sha_block_t  blk;
		sha_digest_t st;
		pad_q = msg;
		nbits = 64'(msg.size()) << 3;
		pad_q.push_back(8'h80);
		while (pad_q.size() % 64 != 56)
			pad_q.push_back(8'h00);
		for (int i = 7; i >= 0; i--)
			pad_q.push_back(nbits[8 * i +: 8]);  // Length big-endian
		st = SHA_H0;
		for (int b = 0; b < pad_q.size(); b += 64) begin
			for (int i = 0; i < 64; i++)
				blk[511 - 8 * i -: 8] = pad_q[b + i];
			st = compress_ref(st, blk);
		end
		return st;
	endfunction

	function automatic sha_digest_t hmac_ref(input hmac_key_t k, input byte_q_t msg);
		byte_q_t     inner;
		byte_q_t     outer;
		sha_digest_t inner_dig;
		for (int i = 0; i < 64; i++) begin
			inner.push_back(k[511 - 8 * i -: 8] ^ 8'h36);
			outer.push_back(k[511 - 8 * i -: 8] ^ 8'h5c);
		end
		foreach (msg[i])
			inner.push_back(msg[i]);
		inner_dig = sha256_ref(inner);
		for (int i = 0; i < 32; i++)
			outer.push_back(inner_dig[255 - 8 * i -: 8]);
		return sha256_ref(outer);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Table and stimulus

	task automatic add_test(input string name, input hmac_key_t k, input logic [511:0] msg,
		input int len, input sha_digest_t mac);
		test_name.push_back(name);
		test_key.push_back(k);
		test_msg.push_back(msg);
		test_len.push_back(len);
		test_mac.push_back(mac);
	endtask

	task automatic fill_table();
		add_test("rfc4231_case1", {{20{8'h0b}}, 352'h0}, {"Hi There", 448'h0}, 8,
			256'hb0344c61d8db38535ca8afceaf0bf12b881dc200c9833da726e9376c2e32cff7);
		add_test("rfc4231_case2", {"Jefe", 480'h0},
			{"what do ya want for nothing?", 288'h0}, 28,
			256'h5bdcc146bf60754e6a042426089575c75a003f089d2739839dec58b964ec3843);
		// 60 bytes push the inner padding into a second block
		add_test("jefe_60_bytes", {"Jefe", 480'h0}, {{6{"0123456789"}}, 32'h0}, 60, '0);
		// Same key again without a key_update
		add_test("jefe_repeat", {"Jefe", 480'h0},
			{"what do ya want for nothing?", 288'h0}, 28,
			256'h5bdcc146bf60754e6a042426089575c75a003f089d2739839dec58b964ec3843);
		add_test("rfc4231_case3", {{20{8'haa}}, 352'h0}, {{50{8'hdd}}, 112'h0}, 50,
			256'h773ea91e36800e46854db8ebd09181a72959098b3ef8c122d9635514ced565fe);
	endtask

	function automatic byte_q_t msg_bytes(input int t);
		byte_q_t q;
		for (int i = 0; i < test_len[t]; i++)
			q.push_back(test_msg[t][511 - 8 * i -: 8]);
		return q;
	endfunction

	// Words go out only while ready with 0 to 3 idle cycles between them
	task automatic send_message(input int t);
		int nwords;
		int w;
		int gap;
		int left;
		nwords = (test_len[t] + 3) / 4;
		w      = 0;
		gap    = 0;
		while (w < nwords) begin
			update = 1'b0;
			if (gap > 0) begin
				gap--;
			end else if (ready) begin
				left        = test_len[t] - 4 * w;
				data_in     = test_msg[t][511 - 32 * w -: 32];
				bytes_valid = (left >= 4) ? 3'd4 : 3'(left);  // Only the last may be partial
				update      = 1'b1;
				w++;
				gap = $urandom_range(3);
			end
			@(posedge clk);
			#2;
		end
		update   = 1'b0;
		finalize = 1'b1;  // Core holds it if a block is still compressing
		@(posedge clk);
		#2;
		finalize = 1'b0;
	endtask

	task automatic wait_for_mac(output sha_digest_t mac);
		while (!hash_valid) begin
			@(posedge clk);
			#2;
		end
		mac = hash;
	endtask

	task automatic run_test(input int t);
		sha_digest_t expected;
		sha_digest_t mac;
		expected = hmac_ref(test_key[t], msg_bytes(t));
		if (test_mac[t] != '0)
			check_digest({test_name[t], " reference model"}, test_mac[t], expected);
		if (!key_loaded || test_key[t] !== cur_key) begin
			key        = test_key[t];
			key_update = 1'b1;
			@(posedge clk);
			#2;
			key_update = 1'b0;
			cur_key    = test_key[t];
			key_loaded = 1'b1;
		end
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		send_message(t);
		wait_for_mac(mac);
		check_digest(test_name[t], expected, mac);
	endtask

	initial begin
		int blocks;
		key_update  = 1'b0;
		key         = '0;
		start       = 1'b0;
		update      = 1'b0;
		data_in     = '0;
		bytes_valid = 3'd4;
		finalize    = 1'b0;
		void'($urandom(58753));
		fill_table();
		// ipad, inner message blocks, opad and digest block
		blocks = 0;
		foreach (test_len[t])
			blocks += 3 + (test_len[t] + 72) / 64;
		cycle_limit = blocks * 80 + 200;
		@(posedge rst_n);
		@(posedge clk);
		#2;
		foreach (test_len[t])
			run_test(t);
		@(posedge clk);  // Edge after the last hash_valid pulse
		#2;
		if (DUT.u_sva.fail_cnt != 0) begin
			$display("A protocol assertion on the core failed");
			stop_with_failure();
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* hmac_sha256_core.f */
src/sha256_pkg.sv
src/hmac_pkg.sv
src/sha256_padder.sv
src/sha256_compress.sv
src/streaming_sha256.sv
src/hmac_sha256_core.sv
verification/tb_clock_gen.sv
verification/hmac_sha256_core_sva.sv
verification/hmac_sha256_tb.sv
